// File: files.f
+incdir+rtl
rtl/synth_pkg.sv
rtl/note_scheduler.sv
rtl/note_bank.sv
rtl/voice_mixer.sv
rtl/lite_regfile.sv
rtl/synth_top.sv
testbench/tb_synth_top.sv

// File: rtl/lite_regfile.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module lite_regfile (
  input  logic                   clk_calc,
  input  logic                   arst_n,
  input  logic [`LITE_LANES-1:0] lite_wstrb,
  input  logic                   lite_rden,
  input  logic [31:0]            lite_addr,
  input  logic [31:0]            lite_wr_data,
  output logic [31:0]            lite_rd_data
);

  logic [`LITE_ADDR_MSB-`LITE_ADDR_LSB:0] word_idx;
  logic [31:0]                           rd_word;

  // word select out of the byte address
  assign word_idx = lite_addr[`LITE_ADDR_MSB:`LITE_ADDR_LSB];

  // one byte-wide array per lane
  for (genvar k = 0; k < `LITE_LANES; k++) begin : g_lane
    logic [7:0] lane_mem [`LITE_DEPTH];

    // strobe alone enables the lane write
    always_ff @(posedge clk_calc) begin
      if (lite_wstrb[k]) begin
        lane_mem[word_idx] <= lite_wr_data[k*8 +: 8];
      end
    end

    assign rd_word[k*8 +: 8] = lane_mem[word_idx];
  end

  // registered read
  // same-cycle write is seen on the next read
  always_ff @(posedge clk_calc or negedge arst_n) begin
    if (!arst_n) begin
      lite_rd_data <= '0;
    end else if (lite_rden) begin
      lite_rd_data <= rd_word;
    end
  end

endmodule

// File: rtl/note_bank.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module note_bank (
  input  logic                clk_calc,
  input  logic                arst_n,
  input  logic                note_on,
  input  logic                note_off,
  input  synth_pkg::period_t  note_period,
  output synth_pkg::sample_t  sample,
  output logic                done
);

  synth_pkg::bank_state_e state;
  synth_pkg::period_t     period_q;
  synth_pkg::period_t     cnt;
  logic                   half_end;

  // last cycle of the current half-wave
  assign half_end = (cnt == period_q - 23'd1);

  always_ff @(posedge clk_calc or negedge arst_n) begin
    if (!arst_n) begin
      state  <= synth_pkg::BANK_IDLE;
      cnt    <= '0;
      sample <= '0;
      done   <= 1'b0;
    end else begin
      // done is a single pulse
      done <= 1'b0;
      if (note_on) begin
        // start or restart, always on the positive half
        state  <= synth_pkg::BANK_PLAYING;
        cnt    <= '0;
        sample <= `SYNTH_TONE_AMPLITUDE;
      end else if (note_off && state == synth_pkg::BANK_PLAYING) begin
        state  <= synth_pkg::BANK_IDLE;
        cnt    <= '0;
        sample <= '0;
        done   <= 1'b1;
      end else if (state == synth_pkg::BANK_PLAYING) begin
        if (half_end) begin
          // flip polarity
          cnt    <= '0;
          sample <= -sample;
        end else begin
          cnt <= cnt + 23'd1;
        end
      end
      // note_off while idle is ignored
    end
  end

  // period latch
  always_ff @(posedge clk_calc) begin
    if (note_on) begin
      period_q <= note_period;
    end
  end

endmodule

// File: rtl/note_scheduler.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module note_scheduler #(
  parameter int NUM_BANKS = `SYNTH_NUM_BANKS
) (
  input  logic                        clk_calc,
  input  logic                        arst_n,
  input  logic                        cmd_valid,
  input  logic [`SYNTH_CMD_W-1:0]     cmd_data,
  input  logic [NUM_BANKS-1:0]        bank_done,
  output logic [NUM_BANKS-1:0]        note_on,
  output logic [NUM_BANKS-1:0]        note_off,
  output synth_pkg::period_t          note_period,
  output logic                        done_valid,
  output synth_pkg::bank_idx_t        done_bank
);

  logic                    cmd_valid_q;
  logic [`SYNTH_CMD_W-1:0] cmd_data_q;
  synth_pkg::bank_idx_t    cmd_bank;
  synth_pkg::period_t      cmd_period;
  synth_pkg::note_op_e     cmd_op;
  logic [NUM_BANKS-1:0]    on_next;
  logic [NUM_BANKS-1:0]    off_next;
  logic                    done_any;
  synth_pkg::bank_idx_t    done_idx;

  // command capture at edge 0
  always_ff @(posedge clk_calc or negedge arst_n) begin
    if (!arst_n) begin
      cmd_valid_q <= 1'b0;
      cmd_data_q  <= '0;
    end else begin
      cmd_valid_q <= cmd_valid;
      if (cmd_valid) begin
        cmd_data_q <= cmd_data;
      end
    end
  end

  // command field split
  assign cmd_bank   = cmd_data_q[`SYNTH_BANK_MSB:`SYNTH_BANK_LSB];
  assign cmd_period = cmd_data_q[`SYNTH_PERIOD_MSB:`SYNTH_PERIOD_LSB];
  assign cmd_op     = (cmd_period != '0) ? synth_pkg::OP_NOTE_ON : synth_pkg::OP_NOTE_OFF;

  // one-hot decode
  // banks at or above NUM_BANKS never match
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      on_next[i]  = cmd_valid_q && (cmd_bank == i) && (cmd_op == synth_pkg::OP_NOTE_ON);
      off_next[i] = cmd_valid_q && (cmd_bank == i) && (cmd_op == synth_pkg::OP_NOTE_OFF);
    end
  end

  // done priority
  // ascending scan so the highest bank wins
  always_comb begin
    done_any = 1'b0;
    done_idx = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      if (bank_done[i]) begin
        done_any = 1'b1;
        done_idx = synth_pkg::bank_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_calc or negedge arst_n) begin
    if (!arst_n) begin
      note_on    <= '0;
      note_off   <= '0;
      done_valid <= 1'b0;
      done_bank  <= '0;
    end else begin
      // single-cycle strobes
      note_on    <= on_next;
      note_off   <= off_next;
      done_valid <= done_any;
      if (done_any) begin
        done_bank <= done_idx;
      end
    end
  end

  // period bus shared by all banks
  // only meaningful alongside a note_on bit
  always_ff @(posedge clk_calc) begin
    if (cmd_valid_q) begin
      note_period <= cmd_period;
    end
  end

endmodule

// File: rtl/synth_consts.svh
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// default voice count
`define SYNTH_NUM_BANKS 4

// host command word
`define SYNTH_CMD_W 32

// period field of the command word
`define SYNTH_PERIOD_MSB 22
`define SYNTH_PERIOD_LSB 0

// bank select field of the command word
`define SYNTH_BANK_MSB 27
`define SYNTH_BANK_LSB 23

// audio sample width
`define SYNTH_SAMPLE_W 24

// per-voice square amplitude
// four voices at full swing stay inside the signed range
`define SYNTH_TONE_AMPLITUDE 24'h100000

// register file geometry
`define LITE_DEPTH 32
`define LITE_ADDR_MSB 6
`define LITE_ADDR_LSB 2
`define LITE_LANES 4

`endif

// File: rtl/synth_pkg.sv
`include "synth_consts.svh"

package synth_pkg;

  // signed audio sample
  typedef logic signed [`SYNTH_SAMPLE_W-1:0] sample_t;

  // tone half-period in clk_calc cycles
  typedef logic [`SYNTH_PERIOD_MSB-`SYNTH_PERIOD_LSB:0] period_t;

  // bank number as carried in the command
  typedef logic [`SYNTH_BANK_MSB-`SYNTH_BANK_LSB:0] bank_idx_t;

  // voice state
  typedef enum logic {
    BANK_IDLE,
    BANK_PLAYING
  } bank_state_e;

  // command opcode
  // a zero period means note off
  typedef enum logic {
    OP_NOTE_OFF,
    OP_NOTE_ON
  } note_op_e;

endpackage

// File: rtl/synth_top.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module synth_top #(
  parameter int NUM_BANKS = `SYNTH_NUM_BANKS
) (
  input  logic                    clk_calc,
  input  logic                    arst_n,
  // note command
  input  logic                    cmd_valid,
  input  logic [`SYNTH_CMD_W-1:0] cmd_data,
  // finished bank report
  output logic                    done_valid,
  output synth_pkg::bank_idx_t    done_bank,
  // mixed sample
  output synth_pkg::sample_t      audio,
  // register file bus
  // lite_wren has no effect, the byte strobes qualify writes
  input  logic                    lite_wren,
  input  logic [`LITE_LANES-1:0]  lite_wstrb,
  input  logic                    lite_rden,
  input  logic [31:0]             lite_addr,
  input  logic [31:0]             lite_wr_data,
  output logic [31:0]             lite_rd_data
);

  logic [NUM_BANKS-1:0]                 note_on;
  logic [NUM_BANKS-1:0]                 note_off;
  synth_pkg::period_t                   note_period;
  logic [NUM_BANKS-1:0]                 bank_done;
  logic [NUM_BANKS*`SYNTH_SAMPLE_W-1:0] bank_samples;

  // command decode and done report
  note_scheduler #(
    .NUM_BANKS(NUM_BANKS)
  ) u_note_scheduler (
    .clk_calc    (clk_calc),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd_data    (cmd_data),
    .bank_done   (bank_done),
    .note_on     (note_on),
    .note_off    (note_off),
    .note_period (note_period),
    .done_valid  (done_valid),
    .done_bank   (done_bank)
  );

  // voices
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    note_bank u_note_bank (
      .clk_calc    (clk_calc),
      .arst_n      (arst_n),
      .note_on     (note_on[i]),
      .note_off    (note_off[i]),
      .note_period (note_period),
      .sample      (bank_samples[i*`SYNTH_SAMPLE_W +: `SYNTH_SAMPLE_W]),
      .done        (bank_done[i])
    );
  end

  voice_mixer #(
    .NUM_BANKS(NUM_BANKS)
  ) u_voice_mixer (
    .clk_calc     (clk_calc),
    .arst_n       (arst_n),
    .bank_samples (bank_samples),
    .audio        (audio)
  );

  lite_regfile u_lite_regfile (
    .clk_calc     (clk_calc),
    .arst_n       (arst_n),
    .lite_wstrb   (lite_wstrb),
    .lite_rden    (lite_rden),
    .lite_addr    (lite_addr),
    .lite_wr_data (lite_wr_data),
    .lite_rd_data (lite_rd_data)
  );

endmodule

// File: rtl/voice_mixer.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module voice_mixer #(
  parameter int NUM_BANKS = `SYNTH_NUM_BANKS
) (
  input  logic                                   clk_calc,
  input  logic                                   arst_n,
  input  logic [NUM_BANKS*`SYNTH_SAMPLE_W-1:0]   bank_samples,
  output synth_pkg::sample_t                     audio
);

  synth_pkg::sample_t mix_sum;

  // signed sum across all voices
  always_comb begin
    mix_sum = '0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      mix_sum = mix_sum + $signed(bank_samples[i*`SYNTH_SAMPLE_W +: `SYNTH_SAMPLE_W]);
    end
  end

  // one register stage on the output
  always_ff @(posedge clk_calc or negedge arst_n) begin
    if (!arst_n) begin
      audio <= '0;
    end else begin
      audio <= mix_sum;
    end
  end

endmodule

// File: testbench/tb_synth_top.sv
`timescale 1ns/10ps
`include "synth_consts.svh"

module tb_synth_top;

  localparam int NB = 4;
  localparam int CLK_PERIOD = 40;
  localparam int AMP = `SYNTH_TONE_AMPLITUDE;
  // phase lengths in cycles, shared by stimulus and watchdog
  localparam int RAND_BUS = 60;
  localparam int TONE_WAIT = 60;
  localparam int MIX_WAIT = 80;
  localparam int TEST_CYCLES = 13 + (66 + RAND_BUS) + (2 + TONE_WAIT) + (6 + MIX_WAIT)
                               + 60 + 60;
  localparam int MARGIN = 200;

  logic                    clk_calc;
  logic                    arst_n;
  logic                    cmd_valid;
  logic [`SYNTH_CMD_W-1:0] cmd_data;
  logic                    done_valid;
  synth_pkg::bank_idx_t    done_bank;
  synth_pkg::sample_t      audio;
  logic                    lite_wren;
  logic [`LITE_LANES-1:0]  lite_wstrb;
  logic                    lite_rden;
  logic [31:0]             lite_addr;
  logic [31:0]             lite_wr_data;
  logic [31:0]             lite_rd_data;

  int errors = 0;

  // reference model state
  logic        c1_valid, c2_valid;
  logic [31:0] c1_data, c2_data;
  logic        m_play [NB];
  int          m_per [NB];
  int          m_age [NB];
  int          m_smp [NB];
  logic [31:0] m_mem [`LITE_DEPTH];
  logic        dn_valid;
  int          dn_bank;
  logic        exp_done_valid;
  int          exp_done_bank, exp_audio, exp_k;
  logic [31:0] exp_rd;

  synth_top #(.NUM_BANKS(NB)) u_dut (
    .clk_calc     (clk_calc),
    .arst_n       (arst_n),
    .cmd_valid    (cmd_valid),
    .cmd_data     (cmd_data),
    .done_valid   (done_valid),
    .done_bank    (done_bank),
    .audio        (audio),
    .lite_wren    (lite_wren),
    .lite_wstrb   (lite_wstrb),
    .lite_rden    (lite_rden),
    .lite_addr    (lite_addr),
    .lite_wr_data (lite_wr_data),
    .lite_rd_data (lite_rd_data)
  );

  always #(CLK_PERIOD / 2) clk_calc = ~clk_calc;

  // model follows the pipeline: command at edge 0, banks at edge 2, outputs at edge 3
  always @(posedge clk_calc or negedge arst_n) begin : ref_model
    int b, p, sum, k, wi;
    if (!arst_n) begin
      c1_valid <= 1'b0;
      c2_valid <= 1'b0;
      exp_done_valid <= 1'b0;
      exp_done_bank <= 0;
      exp_audio <= 0;
      exp_k <= 0;
      exp_rd <= '0;
      dn_valid = 1'b0;
      dn_bank = 0;
      for (b = 0; b < NB; b++) begin
        m_play[b] = 1'b0;
        m_smp[b] = 0;
        m_age[b] = 0;
      end
    end else begin
      // edge 3, outputs from the banks as they stood after edge 2
      sum = 0;
      k = 0;
      for (b = 0; b < NB; b++) begin
        sum += m_smp[b];
        k += int'(m_play[b]);
      end
      exp_audio <= sum;
      exp_k <= k;
      exp_done_valid <= dn_valid;
      exp_done_bank <= dn_bank;
      // edge 2, sign from age: p cycles positive, then p negative
      dn_valid = 1'b0;
      for (b = 0; b < NB; b++) begin
        if (m_play[b]) begin
          m_age[b] = m_age[b] + 1;
          m_smp[b] = ((m_age[b] / m_per[b]) % 2 == 0) ? AMP : -AMP;
        end
      end
      b = int'(c2_data[`SYNTH_BANK_MSB:`SYNTH_BANK_LSB]);
      p = int'(c2_data[`SYNTH_PERIOD_MSB:`SYNTH_PERIOD_LSB]);
      if (c2_valid && b < NB) begin
        if (p != 0) begin
          m_play[b] = 1'b1;
          m_per[b] = p;
          m_age[b] = 0;
          m_smp[b] = AMP;
        end else if (m_play[b]) begin
          m_play[b] = 1'b0;
          m_smp[b] = 0;
          dn_valid = 1'b1;
          dn_bank = b;
        end
      end
      c2_valid <= c1_valid;
      c2_data <= c1_data;
      c1_valid <= cmd_valid;
      c1_data <= cmd_data;
      // register file, old data wins over a same-cycle write
      wi = int'(lite_addr[`LITE_ADDR_MSB:`LITE_ADDR_LSB]);
      if (lite_rden) begin
        exp_rd <= m_mem[wi];
      end
      for (b = 0; b < `LITE_LANES; b++) begin
        if (lite_wstrb[b]) begin
          m_mem[wi][b*8 +: 8] = lite_wr_data[b*8 +: 8];
        end
      end
    end
  end

  a_audio: assert property (@(posedge clk_calc) disable iff (!arst_n) audio === exp_audio)
    else begin
      $display("error: %0t ns: audio %0d, expected %0d", $time, $sampled(audio),
               $sampled(exp_audio));
      errors++;
    end

  // k voices bound the sum, and it steps in twice the amplitude
  a_mix: assert property (@(posedge clk_calc) disable iff (!arst_n)
    (int'(audio) <= exp_k * AMP) && (int'(audio) >= -exp_k * AMP) &&
    ((int'(audio) - exp_k * AMP) % (2 * AMP) == 0))
    else begin
      $display("error: %0t ns: audio %0d off the grid for %0d voices", $time,
               $sampled(audio), $sampled(exp_k));
      errors++;
    end

  a_done: assert property (@(posedge clk_calc) disable iff (!arst_n)
    done_valid === exp_done_valid)
    else begin
      $display("error: %0t ns: done_valid %b, expected %b", $time, $sampled(done_valid),
               $sampled(exp_done_valid));
      errors++;
    end

  a_done_bank: assert property (@(posedge clk_calc) disable iff (!arst_n)
    !exp_done_valid || done_bank == exp_done_bank)
    else begin
      $display("error: %0t ns: done_bank %0d, expected %0d", $time, $sampled(done_bank),
               $sampled(exp_done_bank));
      errors++;
    end

  a_rd: assert property (@(posedge clk_calc) disable iff (!arst_n) lite_rd_data === exp_rd)
    else begin
      $display("error: %0t ns: lite_rd_data %h, expected %h", $time, $sampled(lite_rd_data),
               $sampled(exp_rd));
      errors++;
    end

  task automatic idle(input int n);
    repeat (n) @(posedge clk_calc);
  endtask

  // one-cycle command strobe
  task automatic send_cmd(input int bank, input int per);
    @(posedge clk_calc);
    cmd_valid <= 1'b1;
    cmd_data <= {4'd0, 5'(bank), 23'(per)};
    @(posedge clk_calc);
    cmd_valid <= 1'b0;
  endtask

  task automatic bus_cycle(input logic [3:0] strb, input logic rd, input logic [31:0] addr,
                           input logic [31:0] data);
    @(posedge clk_calc);
    lite_wren <= |strb;
    lite_wstrb <= strb;
    lite_rden <= rd;
    lite_addr <= addr;
    lite_wr_data <= data;
  endtask

  // bounded wait, exact latency is left to a_done
  task automatic wait_done(input int bank);
    int n;
    n = 0;
    while (done_valid !== 1'b1 && n < 10) begin
      @(posedge clk_calc);
      n++;
    end
    if (n >= 10) begin
      $display("no done report for bank %0d within 10 cycles", bank);
      errors++;
    end
    @(posedge clk_calc);
  endtask

  initial begin : watchdog
    #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
    $display("** FAIL **");
    $finish;
  end

  initial begin : stimulus
    int first;
    logic [31:0] addr;
    void'($urandom(32'he9a657ee));
    clk_calc = 1'b0;
    arst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_data = '0;
    lite_wren = 1'b0;
    lite_wstrb = '0;
    lite_rden = 1'b0;
    lite_addr = '0;
    lite_wr_data = '0;
    idle(3);
    arst_n <= 1'b1;
    idle(10);
    // fill every word, pattern tied to the full address
    for (int i = 0; i < `LITE_DEPTH; i++) begin
      addr = 32'(i * 4);
      bus_cycle(4'hf, 1'b0, addr, {addr[15:0] ^ 16'h3c5a, ~addr[15:0]});
    end
    // random strobes and reads, overlap included
    repeat (RAND_BUS) begin
      bus_cycle(4'($urandom), 1'($urandom), $urandom, $urandom);
    end
    for (int i = 0; i < `LITE_DEPTH; i++) begin
      bus_cycle(4'h0, 1'b1, 32'(i * 4), '0);
    end
    bus_cycle(4'h0, 1'b0, '0, '0);
    // single tone on bank 0
    send_cmd(0, 2 + $urandom % 8);
    idle(TONE_WAIT);
    // three more voices on top
    for (int b = 1; b < NB; b++) begin
      send_cmd(b, 2 + $urandom % 8);
    end
    idle(MIX_WAIT);
    // stop all, rotated start point
    first = $urandom % NB;
    for (int i = 0; i < NB; i++) begin
      send_cmd((first + i) % NB, 0);
      wait_done((first + i) % NB);
    end
    idle(4);
    // stop to an idle bank, then out-of-range banks while bank 1 plays
    send_cmd(2, 0);
    send_cmd(1, 2 + $urandom % 8);
    repeat (8) begin
      send_cmd(NB + $urandom % (32 - NB), ($urandom % 2) * (2 + $urandom % 8));
    end
    idle(10);
    send_cmd(1, 0);
    wait_done(1);
    idle(6);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
